// ==== verilog/trig_core_pkg.sv ====
// Core side types seen by the debug trigger block.
// Widths of the CSR and address words, LSU byte enables, exception
// cause and the privilege level encoding, plus the default trigger count.

`default_nettype none

package trig_core_pkg;

  typedef logic [31:0] word_t;      // CSR value or address
  typedef logic [3:0]  be_t;        // LSU byte enables
  typedef logic [10:0] exc_cause_t; // Exception cause in WB

  // Only user and machine mode exist on this core
  typedef enum logic [1:0] {
    priv_lvl_u = 2'd0,
    priv_lvl_m = 2'd3
  } priv_lvl_t;

  localparam int num_triggers_default = 2; // Must be at least 1

endpackage

`default_nettype wire

// ==== verilog/trig_csr_pkg.sv ====
// Trigger CSR encodings for the debug trigger block.
// Holds the tdata1 field positions, the trigger type and match rule
// encodings, and the fixed reset and tinfo values. Imported by the RTL
// that packs, resolves or decodes tdata1 and tdata2.

`default_nettype none

package trig_csr_pkg;

  // Trigger types, tdata1[31:28]
  typedef enum logic [3:0] {
    ttype_etrigger  = 4'd5,   // Exception trigger
    ttype_mcontrol6 = 4'd6,   // Address match trigger
    ttype_disabled  = 4'd15
  } ttype_t;

  // mcontrol6 match rule, only the WARL legal values
  typedef enum logic [3:0] {
    match_eq = 4'd0,
    match_ge = 4'd2,
    match_lt = 4'd3
  } match_rule_t;

  // Fields common to all tdata1 types
  localparam int unsigned tdata1_type_hi = 31;
  localparam int unsigned tdata1_type_lo = 28;
  localparam int unsigned tdata1_dmode   = 27; // Debug mode access only

  // mcontrol6 fields
  localparam int unsigned mc6_action_hi = 15;
  localparam int unsigned mc6_action_lo = 12;
  localparam int unsigned mc6_match_hi  = 10;
  localparam int unsigned mc6_match_lo  = 7;
  localparam int unsigned mc6_m         = 6;
  localparam int unsigned mc6_u         = 3;
  localparam int unsigned mc6_execute   = 2;
  localparam int unsigned mc6_store     = 1;
  localparam int unsigned mc6_load      = 0;

  // Exception trigger privilege enables
  localparam int unsigned etrig_m = 9;
  localparam int unsigned etrig_u = 6;

  localparam logic [31:0] tdata1_rst_val      = 32'hF800_0000; // Disabled, dmode set
  localparam logic [31:0] tinfo_val           = 32'h0000_8060; // Types 5, 6 and 15
  localparam logic [31:0] etrigger_cause_mask = 32'h0000_08AF; // Causes 0-3, 5, 7, 11

endpackage

`default_nettype wire

// ==== verilog/trig_warl.sv ====
// WARL resolution of tdata1 and tdata2 writes.
// Takes the raw CSR write data and the selected trigger's current
// values and returns what the registers take if the write goes through.
// Purely combinational.

`timescale 1ns/1ps
`default_nettype none

module trig_warl
  import trig_core_pkg::*;
  import trig_csr_pkg::*;
(
  input  word_t csr_wdata_i,
  input  word_t tdata1_cur_i,
  input  word_t tdata2_cur_i,
  output word_t tdata1_next_o,
  output word_t tdata2_next_o
);

  logic [3:0] wr_type;    // Type field of the write data
  logic [3:0] wr_match;   // Match field of the write data
  logic [3:0] cur_type;   // Type of the selected trigger now
  word_t      mc6_word;
  word_t      etrig_word;
  logic       tdata2_bad; // tdata2 enables a cause we cannot trigger on

  assign wr_type  = csr_wdata_i[tdata1_type_hi:tdata1_type_lo];
  assign wr_match = csr_wdata_i[mc6_match_hi:mc6_match_lo];
  assign cur_type = tdata1_cur_i[tdata1_type_hi:tdata1_type_lo];

  assign tdata2_bad = |(tdata2_cur_i & ~etrigger_cause_mask);

  //////////////////////////////////////////////////////////////////////
  // Packed tdata1 candidates
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    mc6_word = '0;                                            // Reserved bits read zero
    mc6_word[tdata1_type_hi:tdata1_type_lo] = ttype_mcontrol6;
    mc6_word[tdata1_dmode]                  = 1'b1;
    mc6_word[mc6_action_hi:mc6_action_lo]   = 4'd1;           // Enter debug mode
    if ((wr_match == match_ge) || (wr_match == match_lt)) begin
      mc6_word[mc6_match_hi:mc6_match_lo] = wr_match;
    end else begin
      mc6_word[mc6_match_hi:mc6_match_lo] = match_eq;         // Unsupported rule
    end
    mc6_word[mc6_m]       = csr_wdata_i[mc6_m];
    mc6_word[mc6_u]       = csr_wdata_i[mc6_u];
    mc6_word[mc6_execute] = csr_wdata_i[mc6_execute];
    mc6_word[mc6_store]   = csr_wdata_i[mc6_store];
    mc6_word[mc6_load]    = csr_wdata_i[mc6_load];
  end

  always_comb begin
    etrig_word = '0;
    etrig_word[tdata1_type_hi:tdata1_type_lo] = ttype_etrigger;
    etrig_word[tdata1_dmode] = 1'b1;
    etrig_word[etrig_m]      = csr_wdata_i[etrig_m];
    etrig_word[etrig_u]      = csr_wdata_i[etrig_u];
    etrig_word[5:0]          = 6'd1;                          // Action, enter debug mode
  end

  // Pick the candidate by the written type
  always_comb begin
    case (wr_type)
      ttype_mcontrol6: tdata1_next_o = mc6_word;
      ttype_etrigger:  tdata1_next_o = tdata2_bad ? tdata1_cur_i : etrig_word;
      default:         tdata1_next_o = tdata1_rst_val;        // Disabled or unknown type
    endcase
  end

  // Exception triggers keep only the implemented cause bits
  assign tdata2_next_o = (cur_type == ttype_etrigger) ? (csr_wdata_i & etrigger_cause_mask)
                                                      : csr_wdata_i;

endmodule

`default_nettype wire

// ==== verilog/trig_csr_file.sv ====
// Trigger CSR front end.
// Holds tselect, steers write strobes to the selected trigger, picks
// the selected trigger's tdata1/tdata2 for read data and WARL, and
// returns the constant tinfo.

`timescale 1ns/1ps
`default_nettype none

module trig_csr_file
  import trig_core_pkg::*;
  import trig_csr_pkg::*;
#(
  parameter int num_triggers = 2
) (
  input  logic                     clk,
  input  logic                     reset_i,
  input  word_t                    csr_wdata_i,
  input  logic                     tselect_we_i,
  input  logic                     tdata1_we_i,
  input  logic                     tdata2_we_i,
  input  word_t [num_triggers-1:0] tdata1_q_i,
  input  word_t [num_triggers-1:0] tdata2_q_i,
  output logic  [num_triggers-1:0] tdata1_wr_o,
  output logic  [num_triggers-1:0] tdata2_wr_o,
  output word_t                    tdata1_next_o,
  output word_t                    tdata2_next_o,
  output word_t                    tselect_rdata_o,
  output word_t                    tdata1_rdata_o,
  output word_t                    tdata2_rdata_o,
  output word_t                    tinfo_rdata_o
);

  word_t tselect_q;

  // tselect is WARL, out of range writes are dropped
  always_ff @(posedge clk) begin
    if (reset_i) begin
      tselect_q <= '0;
    end else if (tselect_we_i && (csr_wdata_i < word_t'(num_triggers))) begin
      tselect_q <= csr_wdata_i;
    end
  end

  // Decode tselect into read data and per trigger strobes
  always_comb begin
    tdata1_rdata_o = tdata1_q_i[0];
    tdata2_rdata_o = tdata2_q_i[0];
    tdata1_wr_o    = '0;
    tdata2_wr_o    = '0;
    for (int i = 0; i < num_triggers; i++) begin
      if (tselect_q == word_t'(i)) begin
        tdata1_rdata_o = tdata1_q_i[i];
        tdata2_rdata_o = tdata2_q_i[i];
        tdata1_wr_o[i] = tdata1_we_i;
        tdata2_wr_o[i] = tdata2_we_i;
      end
    end
  end

  trig_warl i_warl (
    .csr_wdata_i   (csr_wdata_i),
    .tdata1_cur_i  (tdata1_rdata_o),
    .tdata2_cur_i  (tdata2_rdata_o),
    .tdata1_next_o (tdata1_next_o),
    .tdata2_next_o (tdata2_next_o)
  );

  assign tselect_rdata_o = tselect_q;
  assign tinfo_rdata_o   = tinfo_val;  // Read only

endmodule

`default_nettype wire

// ==== verilog/trig_unit.sv ====
// One debug trigger.
// Holds tdata1 and tdata2 and checks the fetch PC (IF), the LSU access
// (EX) and the exception in WB against them. All matches are
// combinational and blocked in debug mode.

`timescale 1ns/1ps
`default_nettype none

module trig_unit
  import trig_core_pkg::*;
  import trig_csr_pkg::*;
(
  input  logic       clk,
  input  logic       reset_i,
  input  logic       tdata1_we_i,
  input  logic       tdata2_we_i,
  input  word_t      tdata1_next_i,
  input  word_t      tdata2_next_i,
  // IF stage
  input  word_t      pc_if_i,
  input  priv_lvl_t  priv_lvl_if_i,
  // EX stage
  input  logic       lsu_valid_ex_i,
  input  word_t      lsu_addr_ex_i,
  input  logic       lsu_we_ex_i,
  input  be_t        lsu_be_ex_i,
  input  priv_lvl_t  priv_lvl_ex_i,
  // WB stage
  input  priv_lvl_t  priv_lvl_wb_i,
  input  logic       debug_mode_i,
  input  logic       exception_in_wb_i,
  input  exc_cause_t exception_cause_wb_i,
  output word_t      tdata1_o,
  output word_t      tdata2_o,
  output logic       match_if_o,
  output logic       match_ex_o,
  output logic       etrigger_wb_o
);

  word_t      tdata1_q;
  word_t      tdata2_q;
  logic [3:0] ttype;
  logic [3:0] rule;
  logic       pc_hit;
  logic       lsu_hit;
  logic       lsu_dir_ok;   // Load or store enabled for this access
  logic [1:0] lsb_hi;       // Highest enabled byte in the word
  logic [1:0] lsb_lo;       // Lowest enabled byte in the word
  logic       cause_hit;

  function automatic logic priv_ok(input logic m_en, input logic u_en, input priv_lvl_t lvl);
    return (m_en && (lvl == priv_lvl_m)) || (u_en && (lvl == priv_lvl_u));
  endfunction

  always_ff @(posedge clk) begin
    if (reset_i) begin
      tdata1_q <= tdata1_rst_val;
      tdata2_q <= '0;
    end else begin
      if (tdata1_we_i) tdata1_q <= tdata1_next_i;
      if (tdata2_we_i) tdata2_q <= tdata2_next_i;
    end
  end

  assign ttype = tdata1_q[tdata1_type_hi:tdata1_type_lo];
  assign rule  = tdata1_q[mc6_match_hi:mc6_match_lo];

  //////////////////////////////////////////////////////////////////////
  // Instruction address match (IF)
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    case (rule)
      match_eq: pc_hit = (pc_if_i == tdata2_q);
      match_ge: pc_hit = (pc_if_i >= tdata2_q);
      default:  pc_hit = (pc_if_i <  tdata2_q);  // match_lt
    endcase
  end

  assign match_if_o = (ttype == ttype_mcontrol6) && tdata1_q[mc6_execute] && pc_hit &&
                      priv_ok(tdata1_q[mc6_m], tdata1_q[mc6_u], priv_lvl_if_i) && !debug_mode_i;

  //////////////////////////////////////////////////////////////////////
  // Load/store address match (EX)
  //////////////////////////////////////////////////////////////////////

  // Byte span of the access inside its word
  always_comb begin
    lsb_hi = 2'd0;
    lsb_lo = 2'd0;
    for (int b = 0; b < 4; b++) begin
      if (lsu_be_ex_i[b]) lsb_hi = 2'(b);
    end
    for (int b = 3; b >= 0; b--) begin
      if (lsu_be_ex_i[b]) lsb_lo = 2'(b);
    end
  end

  always_comb begin
    case (rule)
      match_eq: lsu_hit = (lsu_addr_ex_i[31:2] == tdata2_q[31:2]) &&
                          |(lsu_be_ex_i & (4'b0001 << tdata2_q[1:0]));  // Byte covered
      match_ge: lsu_hit = ({lsu_addr_ex_i[31:2], lsb_hi} >= tdata2_q);
      default:  lsu_hit = ({lsu_addr_ex_i[31:2], lsb_lo} <  tdata2_q);
    endcase
  end

  assign lsu_dir_ok = lsu_we_ex_i ? tdata1_q[mc6_store] : tdata1_q[mc6_load];

  assign match_ex_o = (ttype == ttype_mcontrol6) && lsu_valid_ex_i && lsu_dir_ok && lsu_hit &&
                      priv_ok(tdata1_q[mc6_m], tdata1_q[mc6_u], priv_lvl_ex_i) && !debug_mode_i;

  //////////////////////////////////////////////////////////////////////
  // Exception trigger (WB)
  //////////////////////////////////////////////////////////////////////

  // Only causes 0..31 map onto tdata2 bits
  assign cause_hit = exception_in_wb_i && (exception_cause_wb_i < 11'd32) &&
                     tdata2_q[exception_cause_wb_i[4:0]];

  assign etrigger_wb_o = (ttype == ttype_etrigger) && cause_hit &&
                         priv_ok(tdata1_q[etrig_m], tdata1_q[etrig_u], priv_lvl_wb_i) &&
                         !debug_mode_i;

  assign tdata1_o = tdata1_q;
  assign tdata2_o = tdata2_q;

endmodule

`default_nettype wire

// ==== verilog/debug_triggers.sv ====
// Debug trigger block top level.
// Connects the CSR front end to num_triggers trigger units and ORs
// their IF, EX and WB matches for the core. CSR writes take effect at
// the strobe edge, matches are same cycle.

`timescale 1ns/1ps
`default_nettype none

module debug_triggers
  import trig_core_pkg::*;
#(
  parameter int num_triggers = num_triggers_default
) (
  input  logic       clk,
  input  logic       reset_i,
  // CSR write side
  input  word_t      csr_wdata_i,
  input  logic       tselect_we_i,
  input  logic       tdata1_we_i,
  input  logic       tdata2_we_i,
  // CSR read side
  output word_t      tselect_rdata_o,
  output word_t      tdata1_rdata_o,
  output word_t      tdata2_rdata_o,
  output word_t      tinfo_rdata_o,
  // IF stage
  input  word_t      pc_if_i,
  input  priv_lvl_t  priv_lvl_if_i,
  // EX stage
  input  logic       lsu_valid_ex_i,
  input  word_t      lsu_addr_ex_i,
  input  logic       lsu_we_ex_i,
  input  be_t        lsu_be_ex_i,
  input  priv_lvl_t  priv_lvl_ex_i,
  // WB stage and controller
  input  priv_lvl_t  priv_lvl_wb_i,
  input  logic       debug_mode_i,
  input  logic       exception_in_wb_i,
  input  exc_cause_t exception_cause_wb_i,
  // Matches
  output logic       trigger_match_if_o,  // Instruction address
  output logic       trigger_match_ex_o,  // Load/store address
  output logic       etrigger_wb_o        // Exception
);

  word_t [num_triggers-1:0] tdata1_q;
  word_t [num_triggers-1:0] tdata2_q;
  logic  [num_triggers-1:0] tdata1_wr;
  logic  [num_triggers-1:0] tdata2_wr;
  word_t                    tdata1_next;
  word_t                    tdata2_next;
  logic  [num_triggers-1:0] match_if;
  logic  [num_triggers-1:0] match_ex;
  logic  [num_triggers-1:0] match_wb;

  trig_csr_file #(
    .num_triggers (num_triggers)
  ) i_csr_file (
    .clk             (clk),
    .reset_i         (reset_i),
    .csr_wdata_i     (csr_wdata_i),
    .tselect_we_i    (tselect_we_i),
    .tdata1_we_i     (tdata1_we_i),
    .tdata2_we_i     (tdata2_we_i),
    .tdata1_q_i      (tdata1_q),
    .tdata2_q_i      (tdata2_q),
    .tdata1_wr_o     (tdata1_wr),
    .tdata2_wr_o     (tdata2_wr),
    .tdata1_next_o   (tdata1_next),
    .tdata2_next_o   (tdata2_next),
    .tselect_rdata_o (tselect_rdata_o),
    .tdata1_rdata_o  (tdata1_rdata_o),
    .tdata2_rdata_o  (tdata2_rdata_o),
    .tinfo_rdata_o   (tinfo_rdata_o)
  );

  for (genvar t = 0; t < num_triggers; t++) begin : g_trig
    trig_unit i_trig (
      .clk                  (clk),
      .reset_i              (reset_i),
      .tdata1_we_i          (tdata1_wr[t]),
      .tdata2_we_i          (tdata2_wr[t]),
      .tdata1_next_i        (tdata1_next),
      .tdata2_next_i        (tdata2_next),
      .pc_if_i              (pc_if_i),
      .priv_lvl_if_i        (priv_lvl_if_i),
      .lsu_valid_ex_i       (lsu_valid_ex_i),
      .lsu_addr_ex_i        (lsu_addr_ex_i),
      .lsu_we_ex_i          (lsu_we_ex_i),
      .lsu_be_ex_i          (lsu_be_ex_i),
      .priv_lvl_ex_i        (priv_lvl_ex_i),
      .priv_lvl_wb_i        (priv_lvl_wb_i),
      .debug_mode_i         (debug_mode_i),
      .exception_in_wb_i    (exception_in_wb_i),
      .exception_cause_wb_i (exception_cause_wb_i),
      .tdata1_o             (tdata1_q[t]),
      .tdata2_o             (tdata2_q[t]),
      .match_if_o           (match_if[t]),
      .match_ex_o           (match_ex[t]),
      .etrigger_wb_o        (match_wb[t])
    );
  end

  // Any trigger firing flags the stage
  assign trigger_match_if_o = |match_if;
  assign trigger_match_ex_o = |match_ex;
  assign etrigger_wb_o      = |match_wb;

endmodule

`default_nettype wire

// ==== bench/tb_vectors.svh ====
// Stimulus and expected values for the debug trigger testbench.
// Included inside the testbench module. Each call adds one row, either a
// CSR write or one stage's inputs, with the read data and matches expected
// after it. Trigger 0 carries the match tests, trigger 1 the tselect ones.

task automatic load_table();
  word_t pc;
  rng_state = 32'h6e19_c66b;

  // Out of reset, every trigger disabled
  fetch_at(32'h0000_0000, priv_lvl_m, 1'b0, 1'b0);
  lsu_access(32'h0000_0000, 4'b1111, 1'b0, priv_lvl_m, 1'b0);
  exception_at(11'd11, priv_lvl_m, 1'b0);

  // tselect WARL, trigger 1 keeps its own tdata2
  csr_access(op_tsel, 32'h0000_0001, 32'h1, 32'hF800_0000, 32'h0);
  csr_access(op_tsel, 32'h0000_0005, 32'h1, 32'hF800_0000, 32'h0);       // Out of range
  csr_access(op_td2,  32'h1234_5678, 32'h1, 32'hF800_0000, 32'h1234_5678);
  csr_access(op_tsel, 32'h0000_0000, 32'h0, 32'hF800_0000, 32'h0);
  csr_access(op_tsel, 32'h0000_0001, 32'h1, 32'hF800_0000, 32'h1234_5678);
  csr_access(op_tsel, 32'h0000_0000, 32'h0, 32'hF800_0000, 32'h0);

  // tdata1 WARL on trigger 0
  csr_access(op_td1, 32'h6010_00E4, 32'h0, 32'h6800_1044, 32'h0);        // Match 1 -> eq
  csr_access(op_td1, 32'h9000_0044, 32'h0, 32'hF800_0000, 32'h0);        // Type 9
  csr_access(op_td1, 32'h6000_0044, 32'h0, 32'h6800_1044, 32'h0);
  csr_access(op_td2, 32'h0001_0000, 32'h0, 32'h6800_1044, 32'h0001_0000);
  csr_access(op_td1, 32'h5000_0200, 32'h0, 32'h6800_1044, 32'h0001_0000); // Refused
  csr_access(op_td2, 32'h0000_0804, 32'h0, 32'h6800_1044, 32'h0000_0804);
  csr_access(op_td1, 32'h5000_0200, 32'h0, 32'h5800_0201, 32'h0000_0804);
  csr_access(op_td2, 32'hFFFF_FFFF, 32'h0, 32'h5800_0201, 32'h0000_08AF); // Cause mask

  // Exception trigger, machine mode only, cause 11
  csr_access(op_td2, 32'h0000_0800, 32'h0, 32'h5800_0201, 32'h0000_0800);
  exception_at(11'd11, priv_lvl_m, 1'b1);
  exception_at(11'd2,  priv_lvl_m, 1'b0);
  exception_at(11'd11, priv_lvl_u, 1'b0);
  exception_at(11'd43, priv_lvl_m, 1'b0);   // Low bits alias 11, above 31

  // Instruction address, eq then ge
  csr_access(op_td1, 32'h6000_0044, 32'h0, 32'h6800_1044, 32'h0000_0800);
  csr_access(op_td2, 32'h0000_1000, 32'h0, 32'h6800_1044, 32'h0000_1000);
  fetch_at(32'h0000_1000, priv_lvl_m, 1'b0, 1'b1);
  fetch_at(32'h0000_1004, priv_lvl_m, 1'b0, 1'b0);
  fetch_at(32'h0000_1000, priv_lvl_u, 1'b0, 1'b0);  // u not enabled
  fetch_at(32'h0000_1000, priv_lvl_m, 1'b1, 1'b0);  // Debug mode
  csr_access(op_td1, 32'h6000_014C, 32'h0, 32'h6800_114C, 32'h0000_1000);
  fetch_at(32'h0000_0FFC, priv_lvl_u, 1'b0, 1'b0);
  fetch_at(32'h0000_1000, priv_lvl_u, 1'b0, 1'b1);
  fetch_at(32'h0000_2000, priv_lvl_m, 1'b0, 1'b1);
  fetch_at(32'h0000_2000, priv_lvl_m, 1'b1, 1'b0);

  // Random PCs around the middle of the address space
  csr_access(op_td2, 32'h8000_0000, 32'h0, 32'h6800_114C, 32'h8000_0000);
  for (int i = 0; i < 6; i++) begin
    pc = next_rand();
    fetch_at(pc, priv_lvl_m, 1'b0, pc >= 32'h8000_0000);
  end
  csr_access(op_td1, 32'h6000_01C4, 32'h0, 32'h6800_11C4, 32'h8000_0000);
  for (int i = 0; i < 6; i++) begin
    pc = next_rand();
    fetch_at(pc, priv_lvl_m, 1'b0, pc < 32'h8000_0000);
  end
  fetch_at(32'h0000_0010, priv_lvl_u, 1'b0, 1'b0);

  // Load/store on byte 2 of word 0x2000, load bit only
  csr_access(op_td1, 32'h6000_0041, 32'h0, 32'h6800_1041, 32'h8000_0000);
  csr_access(op_td2, 32'h0000_2002, 32'h0, 32'h6800_1041, 32'h0000_2002);
  lsu_access(32'h0000_2000, 4'b0100, 1'b0, priv_lvl_m, 1'b1);
  lsu_access(32'h0000_2000, 4'b1100, 1'b0, priv_lvl_m, 1'b1);
  lsu_access(32'h0000_2000, 4'b0011, 1'b0, priv_lvl_m, 1'b0);
  lsu_access(32'h0000_2004, 4'b0100, 1'b0, priv_lvl_m, 1'b0);
  lsu_access(32'h0000_2000, 4'b0100, 1'b1, priv_lvl_m, 1'b0);  // Store ignored
  csr_access(op_td1, 32'h6000_0141, 32'h0, 32'h6800_1141, 32'h0000_2002);
  lsu_access(32'h0000_2000, 4'b0011, 1'b0, priv_lvl_m, 1'b0);  // Top byte 0x2001
  lsu_access(32'h0000_2000, 4'b1000, 1'b0, priv_lvl_m, 1'b1);
  lsu_access(32'h0000_2000, 4'b0100, 1'b0, priv_lvl_m, 1'b1);
  csr_access(op_td1, 32'h6000_01C1, 32'h0, 32'h6800_11C1, 32'h0000_2002);
  lsu_access(32'h0000_2000, 4'b1100, 1'b0, priv_lvl_m, 1'b0);  // Bottom byte 0x2002
  lsu_access(32'h0000_2000, 4'b0110, 1'b0, priv_lvl_m, 1'b1);
  lsu_access(32'h0000_1FFC, 4'b1000, 1'b0, priv_lvl_m, 1'b1);
  lsu_access(32'h0000_2000, 4'b0110, 1'b1, priv_lvl_m, 1'b0);
endtask

// ==== bench/tb_debug_triggers.sv ====
// Testbench for the debug trigger block with two triggers.
// Applies the rows of tb_vectors.svh one per clock, checks the match
// outputs mid cycle and the CSR read data just after the edge, then
// prints the error count and the verdict.

`timescale 1ns/1ps
`default_nettype none

module tb_debug_triggers
  import trig_core_pkg::*;
();

  localparam logic [1:0] op_tsel = 2'd1;
  localparam logic [1:0] op_td1  = 2'd2;
  localparam logic [1:0] op_td2  = 2'd3;

  typedef struct packed {
    logic [1:0] op;      // Which CSR is written if any
    word_t      wdata;
    logic       dbg;
    priv_lvl_t  priv;    // Same level in every stage
    word_t      pc;
    logic       lsu_v;
    logic       lsu_we;
    be_t        be;
    word_t      addr;
    logic       exc;
    exc_cause_t cause;
    word_t      e_tsel;  // Read data after the row
    word_t      e_td1;
    word_t      e_td2;
    logic       e_if;    // Matches during the row
    logic       e_ex;
    logic       e_wb;
  } row_t;

  logic       clk;
  logic       reset;
  word_t      csr_wdata;
  logic       tselect_we;
  logic       tdata1_we;
  logic       tdata2_we;
  word_t      tselect_rdata;
  word_t      tdata1_rdata;
  word_t      tdata2_rdata;
  word_t      tinfo_rdata;
  word_t      pc_if;
  priv_lvl_t  priv_if;
  logic       lsu_valid;
  word_t      lsu_addr;
  logic       lsu_we;
  be_t        lsu_be;
  priv_lvl_t  priv_ex;
  priv_lvl_t  priv_wb;
  logic       debug_mode;
  logic       exc_wb;
  exc_cause_t cause_wb;
  logic       match_if;
  logic       match_ex;
  logic       match_wb;

  row_t  rows[$];
  word_t exp_tsel;   // Read data expected so far while building rows
  word_t exp_td1;
  word_t exp_td2;
  word_t rng_state;
  int    errors;

  debug_triggers #(
    .num_triggers (2)
  ) i_dut (
    .clk                  (clk),
    .reset_i              (reset),
    .csr_wdata_i          (csr_wdata),
    .tselect_we_i         (tselect_we),
    .tdata1_we_i          (tdata1_we),
    .tdata2_we_i          (tdata2_we),
    .tselect_rdata_o      (tselect_rdata),
    .tdata1_rdata_o       (tdata1_rdata),
    .tdata2_rdata_o       (tdata2_rdata),
    .tinfo_rdata_o        (tinfo_rdata),
    .pc_if_i              (pc_if),
    .priv_lvl_if_i        (priv_if),
    .lsu_valid_ex_i       (lsu_valid),
    .lsu_addr_ex_i        (lsu_addr),
    .lsu_we_ex_i          (lsu_we),
    .lsu_be_ex_i          (lsu_be),
    .priv_lvl_ex_i        (priv_ex),
    .priv_lvl_wb_i        (priv_wb),
    .debug_mode_i         (debug_mode),
    .exception_in_wb_i    (exc_wb),
    .exception_cause_wb_i (cause_wb),
    .trigger_match_if_o   (match_if),
    .trigger_match_ex_o   (match_ex),
    .etrigger_wb_o        (match_wb)
  );

  //////////////////////////////////////////////////////////////////////
  // Row building
  //////////////////////////////////////////////////////////////////////

  function automatic word_t next_rand();  // xorshift32
    word_t x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  // Idle stage inputs with unchanged read data
  function automatic row_t blank_row();
    row_t r;
    r = '0;
    r.priv   = priv_lvl_m;
    r.e_tsel = exp_tsel;
    r.e_td1  = exp_td1;
    r.e_td2  = exp_td2;
    return r;
  endfunction

  task automatic csr_access(input logic [1:0] op, input word_t wdata,
                            input word_t tsel, input word_t td1, input word_t td2);
    row_t r;
    exp_tsel = tsel;
    exp_td1  = td1;
    exp_td2  = td2;
    r        = blank_row();
    r.op     = op;
    r.wdata  = wdata;
    r.dbg    = 1'b1;  // Debug mode holds all matches low
    rows.push_back(r);
  endtask

  task automatic fetch_at(input word_t pc, input priv_lvl_t priv, input logic dbg,
                          input logic e_if);
    row_t r;
    r      = blank_row();
    r.pc   = pc;
    r.priv = priv;
    r.dbg  = dbg;
    r.e_if = e_if;
    rows.push_back(r);
  endtask

  task automatic lsu_access(input word_t addr, input be_t be, input logic we,
                            input priv_lvl_t priv, input logic e_ex);
    row_t r;
    r        = blank_row();
    r.lsu_v  = 1'b1;
    r.addr   = addr;
    r.be     = be;
    r.lsu_we = we;
    r.priv   = priv;
    r.e_ex   = e_ex;
    rows.push_back(r);
  endtask

  task automatic exception_at(input exc_cause_t cause, input priv_lvl_t priv,
                              input logic e_wb);
    row_t r;
    r       = blank_row();
    r.exc   = 1'b1;
    r.cause = cause;
    r.priv  = priv;
    r.e_wb  = e_wb;
    rows.push_back(r);
  endtask

  `include "tb_vectors.svh"

  //////////////////////////////////////////////////////////////////////
  // Driving and checking
  //////////////////////////////////////////////////////////////////////

  task automatic apply_row(input row_t r);
    csr_wdata  = r.wdata;
    tselect_we = (r.op == op_tsel);
    tdata1_we  = (r.op == op_td1);
    tdata2_we  = (r.op == op_td2);
    pc_if      = r.pc;
    priv_if    = r.priv;
    priv_ex    = r.priv;
    priv_wb    = r.priv;
    lsu_valid  = r.lsu_v;
    lsu_addr   = r.addr;
    lsu_we     = r.lsu_we;
    lsu_be     = r.be;
    debug_mode = r.dbg;
    exc_wb     = r.exc;
    cause_wb   = r.cause;
  endtask

  // Polls the clock in 1 ns steps and gives up after two periods
  task automatic wait_level(input logic lvl);
    int waited;
    waited = 0;
    while (clk !== lvl && waited < 200) begin
      #1;
      waited++;
    end
    if (clk !== lvl) begin
      errors++;
      $display("Timed out after %0d ns waiting for the clock to reach %b", waited, lvl);
    end
  endtask

  task automatic verify_word(input string name, input word_t exp, input word_t act);
    assert (act === exp) else begin
      errors++;
      $display("** Error at time %0t: %s expected %h, got %h", $time, name, exp, act);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    assert (act === exp) else begin
      errors++;
      $display("** Error at time %0t: %s expected %b, got %b", $time, name, exp, act);
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;  // 100 ns period
  end

  initial begin
    errors   = 0;
    reset    = 1'b1;
    exp_tsel = '0;
    exp_td1  = 32'hF800_0000;
    exp_td2  = '0;
    apply_row(blank_row());
    load_table();
    wait_level(1'b0);  // Two reset edges
    wait_level(1'b1);
    wait_level(1'b0);
    wait_level(1'b1);
    #1 reset = 1'b0;
    for (int i = 0; i < rows.size(); i++) begin
      apply_row(rows[i]);
      wait_level(1'b0);  // Mid cycle with stage inputs settled
      check_flag("trigger_match_if_o", rows[i].e_if, match_if);
      check_flag("trigger_match_ex_o", rows[i].e_ex, match_ex);
      check_flag("etrigger_wb_o", rows[i].e_wb, match_wb);
      wait_level(1'b1);
      #1;                // Write of this row now visible
      verify_word("tselect_rdata_o", rows[i].e_tsel, tselect_rdata);
      verify_word("tdata1_rdata_o", rows[i].e_td1, tdata1_rdata);
      verify_word("tdata2_rdata_o", rows[i].e_td2, tdata2_rdata);
      verify_word("tinfo_rdata_o", 32'h0000_8060, tinfo_rdata);
    end
    apply_row(blank_row());  // Drop the last strobe
    $display("Applied %0d rows, %0d errors", rows.size(), errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+bench
verilog/trig_core_pkg.sv
verilog/trig_csr_pkg.sv
verilog/trig_warl.sv
verilog/trig_csr_file.sv
verilog/trig_unit.sv
verilog/debug_triggers.sv
bench/tb_debug_triggers.sv

// ==== Makefile ====
# Verilator flow for the debug trigger block.
# make builds and runs the testbench, make lint checks the design,
# make clean removes the build directory.

TOP = tb_debug_triggers

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -f files.f --top-module $(TOP) -o sim
	@out=$$(./obj_dir/sim); \
	echo "$$out"; \
	echo "$$out" | grep -q "^Test passed$$"

lint:
	verilator --lint-only --timing -f files.f --top-module debug_triggers

clean:
	rm -rf obj_dir
